// File: sources.f
+incdir+hw
hw/llc_ctrl_pkg.sv
hw/llc_bus_pkg.sv
hw/llc_input_decoder.sv
hw/llc_localmem.sv
hw/llc_lookup_way.sv
hw/llc_process_request.sv
hw/llc_rsp_out.sv
hw/llc_top.sv
tb/llc_mem_model.sv
tb/tb_llc.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_llc -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_llc > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// File: tb/tb_llc.sv
`timescale 1ns/1ps
`include "llc_consts.svh"

module tb_llc;

    typedef struct packed {
        llc_ctrl_pkg::req_op_t op;
        llc_bus_pkg::line_addr_t addr;
        llc_bus_pkg::line_t wr_line;
        logic [3:0] stall;
        llc_bus_pkg::line_t exp_line;
        logic exp_wb;
        llc_bus_pkg::line_addr_t wb_addr;
        llc_bus_pkg::line_t wb_line;
        logic exp_fill;
    } test_entry_t;

    localparam int SETS = 2 ** `LLC_SET_BITS;
    localparam int LINES = 2 ** (`LLC_TAG_BITS + `LLC_SET_BITS);
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_ENTRY = 200;

    logic clk = 1'b0;
    logic rst;
    llc_bus_pkg::llc_req_in_t req;
    logic req_valid;
    logic req_ready;
    llc_bus_pkg::llc_mem_req_t mem_req;
    logic mem_req_valid;
    logic mem_req_ready;
    llc_bus_pkg::llc_mem_rsp_t mem_rsp;
    logic mem_rsp_valid;
    logic mem_rsp_ready;
    llc_bus_pkg::llc_rsp_out_t rsp;
    logic rsp_valid;
    logic rsp_ready;

    test_entry_t table_q[$];
    llc_bus_pkg::llc_mem_req_t mem_ops[$];
    llc_bus_pkg::line_t shadow [LINES];
    // expected tag state while the table is built
    llc_ctrl_pkg::llc_tag_t ref_tag [SETS][`LLC_WAYS];
    logic ref_valid [SETS][`LLC_WAYS];
    logic ref_dirty [SETS][`LLC_WAYS];
    llc_ctrl_pkg::llc_way_t ref_ptr [SETS];
    int cycle_count = 0;
    int cycle_limit = RESET_CYCLES + CYCLES_PER_ENTRY;
    logic mem_wait = 1'b0;
    llc_bus_pkg::llc_mem_req_t mem_held;

    always #4 clk = ~clk;

    llc_top dut (
        .clk(clk),
        .rst(rst),
        .req_i(req),
        .req_valid_i(req_valid),
        .req_ready_o(req_ready),
        .mem_req_o(mem_req),
        .mem_req_valid_o(mem_req_valid),
        .mem_req_ready_i(mem_req_ready),
        .mem_rsp_i(mem_rsp),
        .mem_rsp_valid_i(mem_rsp_valid),
        .mem_rsp_ready_o(mem_rsp_ready),
        .rsp_o(rsp),
        .rsp_valid_o(rsp_valid),
        .rsp_ready_i(rsp_ready)
    );

    llc_mem_model u_mem_model (
        .clk(clk),
        .rst(rst),
        .mem_req_i(mem_req),
        .mem_req_valid_i(mem_req_valid),
        .mem_req_ready_o(mem_req_ready),
        .mem_rsp_o(mem_rsp),
        .mem_rsp_valid_o(mem_rsp_valid),
        .mem_rsp_ready_i(mem_rsp_ready)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got=%0h exp=%0h", $time, name, got, exp));
        end
    endtask

    // same contents the memory holds at power-on
    function automatic llc_bus_pkg::line_t initial_line(input llc_bus_pkg::line_addr_t addr);
        return {~addr, 8'h3c, addr};
    endfunction

    task automatic add_entry(input llc_ctrl_pkg::req_op_t op, input llc_bus_pkg::line_addr_t addr,
                             input llc_bus_pkg::line_t wr_line, input int stall);
        test_entry_t e;
        llc_ctrl_pkg::llc_set_t set_idx;
        llc_ctrl_pkg::llc_tag_t tag;
        llc_ctrl_pkg::llc_way_t v;
        int way;
        int w;
        set_idx = addr[`LLC_SET_BITS-1:0];
        tag = addr[`LLC_TAG_BITS+`LLC_SET_BITS-1:`LLC_SET_BITS];
        e = '0;
        e.op = op;
        e.addr = addr;
        e.wr_line = wr_line;
        e.stall = 4'(stall);
        way = -1;
        for (w = 0; w < `LLC_WAYS; w++) begin
            if (ref_valid[set_idx][w] && ref_tag[set_idx][w] == tag) begin
                way = w;
            end
        end
        // miss replaces the way under the round-robin pointer
        if (way < 0) begin
            v = ref_ptr[set_idx];
            e.exp_fill = 1'b1;
            if (ref_valid[set_idx][v] && ref_dirty[set_idx][v]) begin
                e.exp_wb = 1'b1;
                e.wb_addr = {ref_tag[set_idx][v], set_idx};
                e.wb_line = shadow[e.wb_addr];
            end
            ref_valid[set_idx][v] = 1'b1;
            ref_tag[set_idx][v] = tag;
            ref_dirty[set_idx][v] = 1'b0;
            ref_ptr[set_idx] = v + 1'b1;
            way = int'(v);
        end
        if (op == llc_ctrl_pkg::REQ_WRITE) begin
            shadow[addr] = wr_line;
            ref_dirty[set_idx][way] = 1'b1;
        end
        e.exp_line = shadow[addr];
        table_q.push_back(e);
    endtask

    task automatic build_table();
        llc_ctrl_pkg::req_op_t op;
        llc_ctrl_pkg::llc_tag_t tag;
        llc_ctrl_pkg::llc_set_t set_idx;
        int stall;
        int t;
        add_entry(llc_ctrl_pkg::REQ_READ, 12'h013, '0, 0);
        add_entry(llc_ctrl_pkg::REQ_WRITE, 12'h027, 32'h1234_abcd, 0);
        add_entry(llc_ctrl_pkg::REQ_READ, 12'h027, '0, 0);
        // five tags in set 5 so the fifth evicts the first
        for (t = 0; t < 5; t++) begin
            add_entry(llc_ctrl_pkg::REQ_WRITE, {8'h10 + 8'(t), 4'h5}, 32'h5a00_0000 | t, 0);
        end
        add_entry(llc_ctrl_pkg::REQ_READ, 12'h115, '0, 0);
        // held responses
        add_entry(llc_ctrl_pkg::REQ_READ, 12'h125, '0, $urandom_range(3, 10));
        add_entry(llc_ctrl_pkg::REQ_WRITE, 12'h135, 32'h0f0f_7788, $urandom_range(3, 10));
        add_entry(llc_ctrl_pkg::REQ_READ, 12'h135, '0, $urandom_range(3, 10));
        // eight tags over sets 9 to b keep victims often dirty
        for (t = 0; t < 40; t++) begin
            tag = 8'h20 + 8'($urandom_range(0, 7));
            set_idx = 4'h9 + 4'($urandom_range(0, 2));
            op = ($urandom_range(0, 1) == 1) ? llc_ctrl_pkg::REQ_WRITE : llc_ctrl_pkg::REQ_READ;
            stall = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 4)) : 0;
            add_entry(op, {tag, set_idx}, $urandom, stall);
        end
    endtask

    task automatic apply_entry(input int idx);
        test_entry_t e;
        llc_bus_pkg::llc_rsp_out_t held;
        int wait_cycles;
        int k;
        e = table_q[idx];
        mem_ops.delete();
        req.op = e.op;
        req.addr = e.addr;
        req.line = e.wr_line;
        req.req_id = llc_bus_pkg::req_id_t'(idx);
        req_valid = 1'b1;
        rsp_ready = (e.stall == 0);
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        wait_cycles = 0;
        @(negedge clk);
        while (!rsp_valid) begin
            wait_cycles++;
            if (wait_cycles > CYCLES_PER_ENTRY - 20) begin
                abort_run($sformatf("response for table entry %0d never arrived", idx));
            end
            @(negedge clk);
        end
        held = rsp;
        for (k = 0; k < e.stall; k++) begin
            check_value("req_ready_o", req_ready, 1'b0);
            @(negedge clk);
            check_value("rsp_valid_o", rsp_valid, 1'b1);
            check_value("rsp_o", rsp, held);
        end
        if (e.stall != 0) begin
            @(posedge clk);
            #1;
            rsp_ready = 1'b1;
            @(negedge clk);
            check_value("rsp_valid_o", rsp_valid, 1'b1);
            check_value("rsp_o", rsp, held);
        end
        check_value("rsp_o.op", held.op, e.op);
        check_value("rsp_o.addr", held.addr, e.addr);
        check_value("rsp_o.line", held.line, e.exp_line);
        check_value("rsp_o.req_id", held.req_id, req.req_id);
        check_value("memory transfer count", mem_ops.size(), int'(e.exp_wb) + int'(e.exp_fill));
        if (e.exp_wb) begin
            check_value("mem_req_o.op", mem_ops[0].op, llc_ctrl_pkg::MEM_WRITE);
            check_value("mem_req_o.addr", mem_ops[0].addr, e.wb_addr);
            check_value("mem_req_o.line", mem_ops[0].line, e.wb_line);
        end
        if (e.exp_fill) begin
            check_value("mem_req_o.op", mem_ops[mem_ops.size()-1].op, llc_ctrl_pkg::MEM_READ);
            check_value("mem_req_o.addr", mem_ops[mem_ops.size()-1].addr, e.addr);
        end
        // slot is empty again after the transfer edge
        @(negedge clk);
        check_value("rsp_valid_o", rsp_valid, 1'b0);
        check_value("req_ready_o", req_ready, 1'b1);
        @(posedge clk);
        #1;
    endtask

    // memory requests seen before the edge that completes them
    always @(negedge clk) begin
        if (rst) begin
            if (mem_wait) begin
                check_value("mem_req_valid_o", mem_req_valid, 1'b1);
                check_value("mem_req_o", mem_req, mem_held);
            end
            if (mem_req_valid && mem_req_ready) begin
                mem_ops.push_back(mem_req);
            end
            mem_wait = mem_req_valid && !mem_req_ready;
            mem_held = mem_req;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, the test did not finish", cycle_count));
        end
    end

    initial begin
        int wait_cycles;
        void'($urandom(32'h21ed));
        rst = 1'b0;
        req = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        for (int a = 0; a < LINES; a++) begin
            shadow[a] = initial_line(llc_bus_pkg::line_addr_t'(a));
        end
        for (int s = 0; s < SETS; s++) begin
            ref_ptr[s] = '0;
            for (int w = 0; w < `LLC_WAYS; w++) begin
                ref_tag[s][w] = '0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        build_table();
        cycle_limit = RESET_CYCLES + CYCLES_PER_ENTRY * table_q.size();

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("req_ready_o", req_ready, 1'b0);
        check_value("rsp_valid_o", rsp_valid, 1'b0);
        check_value("mem_req_valid_o", mem_req_valid, 1'b0);
        check_value("mem_rsp_ready_o", mem_rsp_ready, 1'b0);
        @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        check_value("rsp_valid_o", rsp_valid, 1'b0);
        check_value("mem_req_valid_o", mem_req_valid, 1'b0);
        wait_cycles = 0;
        while (!req_ready) begin
            wait_cycles++;
            if (wait_cycles > 4) begin
                abort_run("req_ready_o did not rise after reset was released");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;

        for (int i = 0; i < table_q.size(); i++) begin
            apply_entry(i);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: tb/llc_mem_model.sv
`timescale 1ns/1ps
`include "llc_consts.svh"

module llc_mem_model (
    input  logic clk,
    input  logic rst,
    input  llc_bus_pkg::llc_mem_req_t mem_req_i,
    input  logic mem_req_valid_i,
    output logic mem_req_ready_o,
    output llc_bus_pkg::llc_mem_rsp_t mem_rsp_o,
    output logic mem_rsp_valid_o,
    input  logic mem_rsp_ready_i
);

    localparam int LINES = 2 ** (`LLC_TAG_BITS + `LLC_SET_BITS);

    llc_bus_pkg::line_t store [LINES];
    llc_bus_pkg::llc_mem_req_t req_seen;
    llc_bus_pkg::line_addr_t rd_addr;
    logic req_fire;
    logic rsp_fire;
    logic rd_pend;
    int req_wait;
    int rsp_wait;

    function automatic llc_bus_pkg::line_t power_on_line(input llc_bus_pkg::line_addr_t addr);
        return {~addr, 8'h3c, addr};
    endfunction

    // handshakes sampled mid-cycle complete on the next rising edge
    always @(negedge clk) begin
        req_fire = mem_req_valid_i && mem_req_ready_o;
        rsp_fire = mem_rsp_valid_o && mem_rsp_ready_i;
        req_seen = mem_req_i;
    end

    initial begin
        for (int a = 0; a < LINES; a++) begin
            store[a] = power_on_line(llc_bus_pkg::line_addr_t'(a));
        end
        mem_req_ready_o = 1'b0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_o = '0;
        req_fire = 1'b0;
        rsp_fire = 1'b0;
        rd_pend = 1'b0;
        rd_addr = '0;
        req_wait = 0;
        rsp_wait = 0;
        forever begin
            @(posedge clk);
            #1;
            if (rsp_fire) begin
                mem_rsp_valid_o = 1'b0;
            end
            if (req_fire) begin
                mem_req_ready_o = 1'b0;
                req_wait = $urandom_range(0, 3);
                if (req_seen.op == llc_ctrl_pkg::MEM_WRITE) begin
                    store[req_seen.addr] = req_seen.line;
                end else begin
                    rd_pend = 1'b1;
                    rd_addr = req_seen.addr;
                    rsp_wait = $urandom_range(0, 4);
                end
            end else if (rst && mem_req_valid_i && !mem_req_ready_o) begin
                if (req_wait == 0) begin
                    mem_req_ready_o = 1'b1;
                end else begin
                    req_wait--;
                end
            end
            // fill data after a random gap
            if (rd_pend && !mem_rsp_valid_o) begin
                if (rsp_wait == 0) begin
                    mem_rsp_o.line = store[rd_addr];
                    mem_rsp_valid_o = 1'b1;
                    rd_pend = 1'b0;
                end else begin
                    rsp_wait--;
                end
            end
        end
    end

endmodule

// File: hw/llc_top.sv
`timescale 1ns/1ps
`include "llc_consts.svh"

module llc_top (
    input  logic clk,
    input  logic rst,
    input  llc_bus_pkg::llc_req_in_t req_i,
    input  logic req_valid_i,
    output logic req_ready_o,
    output llc_bus_pkg::llc_mem_req_t mem_req_o,
    output logic mem_req_valid_o,
    input  logic mem_req_ready_i,
    input  llc_bus_pkg::llc_mem_rsp_t mem_rsp_i,
    input  logic mem_rsp_valid_i,
    output logic mem_rsp_ready_o,
    output llc_bus_pkg::llc_rsp_out_t rsp_o,
    output logic rsp_valid_o,
    input  logic rsp_ready_i
);

    llc_ctrl_pkg::llc_fsm_state_t state;
    llc_bus_pkg::llc_req_in_t req_q;
    llc_ctrl_pkg::line_breakdown_t line_br;
    llc_ctrl_pkg::llc_tag_t rd_tag [`LLC_WAYS];
    logic rd_valid [`LLC_WAYS];
    logic rd_dirty [`LLC_WAYS];
    llc_bus_pkg::line_t rd_line [`LLC_WAYS];
    llc_ctrl_pkg::llc_way_t rd_evict_way;
    llc_ctrl_pkg::lookup_res_t lookup_res;
    llc_ctrl_pkg::arr_wr_t arr_wr;
    llc_bus_pkg::llc_rsp_out_t rsp_data;
    logic rsp_push;
    logic rsp_busy;
    logic req_fire;

    assign req_fire = req_valid_i && req_ready_o;

    llc_input_decoder u_input_decoder (
        .clk(clk),
        .rst(rst),
        .state_i(state),
        .req_i(req_i),
        .req_valid_i(req_valid_i),
        .rsp_busy_i(rsp_busy),
        .req_ready_o(req_ready_o),
        .req_o(req_q),
        .line_br_o(line_br)
    );

    llc_localmem u_localmem (
        .clk(clk),
        .rst(rst),
        .set_i(line_br.set),
        .wr_i(arr_wr),
        .rd_tag_o(rd_tag),
        .rd_valid_o(rd_valid),
        .rd_dirty_o(rd_dirty),
        .rd_line_o(rd_line),
        .rd_evict_way_o(rd_evict_way)
    );

    llc_lookup_way u_lookup_way (
        .tag_i(line_br.tag),
        .rd_tag_i(rd_tag),
        .rd_valid_i(rd_valid),
        .rd_dirty_i(rd_dirty),
        .rd_line_i(rd_line),
        .rd_evict_way_i(rd_evict_way),
        .res_o(lookup_res)
    );

    llc_process_request u_process_request (
        .clk(clk),
        .rst(rst),
        .req_i(req_q),
        .line_br_i(line_br),
        .lookup_i(lookup_res),
        .req_fire_i(req_fire),
        .mem_req_ready_i(mem_req_ready_i),
        .mem_req_o(mem_req_o),
        .mem_req_valid_o(mem_req_valid_o),
        .mem_rsp_i(mem_rsp_i),
        .mem_rsp_valid_i(mem_rsp_valid_i),
        .mem_rsp_ready_o(mem_rsp_ready_o),
        .state_o(state),
        .wr_o(arr_wr),
        .rsp_push_o(rsp_push),
        .rsp_o(rsp_data)
    );

    llc_rsp_out u_rsp_out (
        .clk(clk),
        .rst(rst),
        .push_i(rsp_push),
        .rsp_i(rsp_data),
        .rsp_ready_i(rsp_ready_i),
        .rsp_o(rsp_o),
        .rsp_valid_o(rsp_valid_o),
        .rsp_busy_o(rsp_busy)
    );

endmodule

// File: hw/llc_rsp_out.sv
`timescale 1ns/1ps

module llc_rsp_out (
    input  logic clk,
    input  logic rst,
    input  logic push_i,
    input  llc_bus_pkg::llc_rsp_out_t rsp_i,
    input  logic rsp_ready_i,
    output llc_bus_pkg::llc_rsp_out_t rsp_o,
    output logic rsp_valid_o,
    output logic rsp_busy_o
);

    // a push always finds the slot empty since one request is in flight
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_valid_o <= 1'b0;
        end else if (push_i) begin
            rsp_valid_o <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
        end
    end

    // held stable until the requester takes it
    always_ff @(posedge clk) begin
        if (push_i) begin
            rsp_o <= rsp_i;
        end
    end

    assign rsp_busy_o = rsp_valid_o;

endmodule

// File: hw/llc_process_request.sv
`timescale 1ns/1ps

module llc_process_request (
    input  logic clk,
    input  logic rst,
    input  llc_bus_pkg::llc_req_in_t req_i,
    input  llc_ctrl_pkg::line_breakdown_t line_br_i,
    input  llc_ctrl_pkg::lookup_res_t lookup_i,
    input  logic req_fire_i,
    input  logic mem_req_ready_i,
    output llc_bus_pkg::llc_mem_req_t mem_req_o,
    output logic mem_req_valid_o,
    input  llc_bus_pkg::llc_mem_rsp_t mem_rsp_i,
    input  logic mem_rsp_valid_i,
    output logic mem_rsp_ready_o,
    output llc_ctrl_pkg::llc_fsm_state_t state_o,
    output llc_ctrl_pkg::arr_wr_t wr_o,
    output logic rsp_push_o,
    output llc_bus_pkg::llc_rsp_out_t rsp_o
);

    llc_ctrl_pkg::llc_fsm_state_t next_state;
    llc_ctrl_pkg::lookup_res_t lookup_q;
    logic wb_pend;
    logic fill_pend;
    logic fill_sent;
    logic process_done;
    logic is_write;
    logic mem_req_fire;
    logic mem_rsp_fire;
    llc_bus_pkg::line_t fill_line;
    llc_bus_pkg::line_t line_out;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_o <= llc_ctrl_pkg::DECODE;
        end else begin
            state_o <= next_state;
        end
    end

    always_comb begin
        next_state = state_o;
        case (state_o)
            llc_ctrl_pkg::DECODE: begin
                if (req_fire_i) begin
                    next_state = llc_ctrl_pkg::READ_SET;
                end
            end
            llc_ctrl_pkg::READ_SET: next_state = llc_ctrl_pkg::LOOKUP;
            llc_ctrl_pkg::LOOKUP: next_state = llc_ctrl_pkg::PROCESS;
            llc_ctrl_pkg::PROCESS: begin
                if (process_done) begin
                    next_state = llc_ctrl_pkg::UPDATE;
                end
            end
            llc_ctrl_pkg::UPDATE: next_state = llc_ctrl_pkg::DECODE;
            default: next_state = llc_ctrl_pkg::DECODE;
        endcase
    end

    assign mem_req_fire = mem_req_valid_o && mem_req_ready_i;
    assign mem_rsp_fire = mem_rsp_valid_i && mem_rsp_ready_o;
    assign process_done = !wb_pend && !fill_pend;

    always_ff @(posedge clk) begin
        if (state_o == llc_ctrl_pkg::LOOKUP) begin
            lookup_q <= lookup_i;
        end
        if (mem_rsp_fire) begin
            fill_line <= mem_rsp_i.line;
        end
    end

    // on a miss the writeback goes before the fill request and the fill data
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_pend <= 1'b0;
            fill_pend <= 1'b0;
            fill_sent <= 1'b0;
        end else if (state_o == llc_ctrl_pkg::LOOKUP) begin
            wb_pend <= !lookup_i.hit && lookup_i.dirty;
            fill_pend <= !lookup_i.hit;
            fill_sent <= 1'b0;
        end else if (state_o == llc_ctrl_pkg::PROCESS) begin
            if (mem_req_fire) begin
                if (wb_pend) begin
                    wb_pend <= 1'b0;
                end else begin
                    fill_sent <= 1'b1;
                end
            end
            if (mem_rsp_fire) begin
                fill_pend <= 1'b0;
            end
        end
    end

    assign mem_req_valid_o = (state_o == llc_ctrl_pkg::PROCESS) &&
                             (wb_pend || (fill_pend && !fill_sent));
    assign mem_rsp_ready_o = (state_o == llc_ctrl_pkg::PROCESS) && fill_sent && fill_pend;

    always_comb begin
        if (wb_pend) begin
            mem_req_o.op = llc_ctrl_pkg::MEM_WRITE;
            mem_req_o.addr = {lookup_q.tag, line_br_i.set};
            mem_req_o.line = lookup_q.line;
        end else begin
            mem_req_o.op = llc_ctrl_pkg::MEM_READ;
            mem_req_o.addr = req_i.addr;
            mem_req_o.line = '0;
        end
    end

    // write data wins, then hit data, then the filled line
    assign is_write = (req_i.op == llc_ctrl_pkg::REQ_WRITE);
    assign line_out = is_write ? req_i.line : (lookup_q.hit ? lookup_q.line : fill_line);

    // read hits leave the arrays alone
    always_comb begin
        wr_o.we = (state_o == llc_ctrl_pkg::UPDATE) && (is_write || !lookup_q.hit);
        wr_o.way = lookup_q.way;
        wr_o.tag = line_br_i.tag;
        wr_o.dirty = is_write;
        wr_o.line = line_out;
        wr_o.evict_adv = !lookup_q.hit;
    end

    assign rsp_push_o = (state_o == llc_ctrl_pkg::UPDATE);

    always_comb begin
        rsp_o.op = req_i.op;
        rsp_o.addr = req_i.addr;
        rsp_o.line = line_out;
        rsp_o.req_id = req_i.req_id;
    end

endmodule

// File: hw/llc_lookup_way.sv
`timescale 1ns/1ps
`include "llc_consts.svh"

module llc_lookup_way (
    input  llc_ctrl_pkg::llc_tag_t tag_i,
    input  llc_ctrl_pkg::llc_tag_t rd_tag_i [`LLC_WAYS],
    input  logic rd_valid_i [`LLC_WAYS],
    input  logic rd_dirty_i [`LLC_WAYS],
    input  llc_bus_pkg::line_t rd_line_i [`LLC_WAYS],
    input  llc_ctrl_pkg::llc_way_t rd_evict_way_i,
    output llc_ctrl_pkg::lookup_res_t res_o
);

    logic hit;
    llc_ctrl_pkg::llc_way_t hit_way;
    llc_ctrl_pkg::llc_way_t way;

    // tag compare over all ways
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int i = 0; i < `LLC_WAYS; i++) begin
            if (rd_valid_i[i] && (rd_tag_i[i] == tag_i)) begin
                hit = 1'b1;
                hit_way = llc_ctrl_pkg::llc_way_t'(i);
            end
        end
    end

    // victim comes from the set's round-robin pointer
    assign way = hit ? hit_way : rd_evict_way_i;

    always_comb begin
        res_o.hit = hit;
        res_o.way = way;
        // an invalid victim never needs a writeback
        res_o.dirty = rd_valid_i[way] & rd_dirty_i[way];
        res_o.tag = rd_tag_i[way];
        res_o.line = rd_line_i[way];
    end

endmodule

// File: hw/llc_localmem.sv
`timescale 1ns/1ps
`include "llc_consts.svh"

module llc_localmem (
    input  logic clk,
    input  logic rst,
    input  logic [`LLC_SET_BITS-1:0] set_i,
    input  llc_ctrl_pkg::arr_wr_t wr_i,
    output llc_ctrl_pkg::llc_tag_t rd_tag_o [`LLC_WAYS],
    output logic rd_valid_o [`LLC_WAYS],
    output logic rd_dirty_o [`LLC_WAYS],
    output llc_bus_pkg::line_t rd_line_o [`LLC_WAYS],
    output llc_ctrl_pkg::llc_way_t rd_evict_way_o
);

    localparam int SETS = 2 ** `LLC_SET_BITS;

    llc_ctrl_pkg::llc_tag_t tag_mem [SETS][`LLC_WAYS];
    llc_bus_pkg::line_t line_mem [SETS][`LLC_WAYS];
    logic dirty_mem [SETS][`LLC_WAYS];
    logic [`LLC_WAYS-1:0] valid_mem [SETS];
    llc_ctrl_pkg::llc_way_t evict_ptr [SETS];

    // valid bits and round-robin pointers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_mem[s] <= '0;
                evict_ptr[s] <= '0;
            end
        end else if (wr_i.we) begin
            valid_mem[set_i][wr_i.way] <= 1'b1;
            if (wr_i.evict_adv) begin
                // 2-bit pointer wraps by itself
                evict_ptr[set_i] <= evict_ptr[set_i] + 1'b1;
            end
        end
    end

    // line storage
    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            tag_mem[set_i][wr_i.way] <= wr_i.tag;
            dirty_mem[set_i][wr_i.way] <= wr_i.dirty;
            line_mem[set_i][wr_i.way] <= wr_i.line;
        end
    end

    // registered read of the whole set
    always_ff @(posedge clk) begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            rd_tag_o[w] <= tag_mem[set_i][w];
            rd_valid_o[w] <= valid_mem[set_i][w];
            rd_dirty_o[w] <= dirty_mem[set_i][w];
            rd_line_o[w] <= line_mem[set_i][w];
        end
        rd_evict_way_o <= evict_ptr[set_i];
    end

endmodule

// File: hw/llc_input_decoder.sv
`timescale 1ns/1ps
`include "llc_consts.svh"

module llc_input_decoder (
    input  logic clk,
    input  logic rst,
    input  llc_ctrl_pkg::llc_fsm_state_t state_i,
    input  llc_bus_pkg::llc_req_in_t req_i,
    input  logic req_valid_i,
    input  logic rsp_busy_i,
    output logic req_ready_o,
    output llc_bus_pkg::llc_req_in_t req_o,
    output llc_ctrl_pkg::line_breakdown_t line_br_o
);

    logic out_of_rst;
    logic req_fire;

    // low during reset, high from the first edge after it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_of_rst <= 1'b0;
        end else begin
            out_of_rst <= 1'b1;
        end
    end

    // one request in flight, and only with an empty response slot
    assign req_ready_o = out_of_rst && (state_i == llc_ctrl_pkg::DECODE) && !rsp_busy_i;
    assign req_fire = req_valid_i && req_ready_o;

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_o <= req_i;
            line_br_o.tag <= req_i.addr[`LLC_TAG_BITS+`LLC_SET_BITS-1:`LLC_SET_BITS];
            line_br_o.set <= req_i.addr[`LLC_SET_BITS-1:0];
        end
    end

endmodule

// File: hw/llc_bus_pkg.sv
`include "llc_consts.svh"

package llc_bus_pkg;

    // tag in the upper bits and set index below
    typedef logic [`LLC_TAG_BITS+`LLC_SET_BITS-1:0] line_addr_t;
    typedef logic [`LINE_BITS-1:0] line_t;
    typedef logic [`REQ_ID_BITS-1:0] req_id_t;

    // requester to cache
    typedef struct packed {
        llc_ctrl_pkg::req_op_t op;
        line_addr_t addr;
        line_t line;
        req_id_t req_id;
    } llc_req_in_t;

    // read data or write acknowledgement to the requester
    typedef struct packed {
        llc_ctrl_pkg::req_op_t op;
        line_addr_t addr;
        line_t line;
        req_id_t req_id;
    } llc_rsp_out_t;

    // writebacks and fills to memory
    typedef struct packed {
        llc_ctrl_pkg::mem_op_t op;
        line_addr_t addr;
        line_t line;
    } llc_mem_req_t;

    // fill data only
    typedef struct packed {
        line_t line;
    } llc_mem_rsp_t;

endpackage

// File: hw/llc_ctrl_pkg.sv
`include "llc_consts.svh"

package llc_ctrl_pkg;

    // step FSM states
    typedef enum logic [2:0] {
        DECODE   = 3'b000,
        READ_SET = 3'b001,
        LOOKUP   = 3'b010,
        PROCESS  = 3'b110,
        UPDATE   = 3'b100
    } llc_fsm_state_t;

    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_op_t;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_t;

    typedef logic [$clog2(`LLC_WAYS)-1:0] llc_way_t;
    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;

    typedef struct packed {
        llc_tag_t tag;
        llc_set_t set;
    } line_breakdown_t;

    // fields describe the hit way, or the victim way on a miss
    typedef struct packed {
        logic hit;
        llc_way_t way;
        logic dirty;
        llc_tag_t tag;
        logic [`LINE_BITS-1:0] line;
    } lookup_res_t;

    typedef struct packed {
        logic we;
        llc_way_t way;
        llc_tag_t tag;
        logic dirty;
        logic [`LINE_BITS-1:0] line;
        logic evict_adv;
    } arr_wr_t;

endpackage

// File: hw/llc_consts.svh
`ifndef LLC_CONSTS_SVH
`define LLC_CONSTS_SVH

// cache geometry
`define LLC_WAYS 4
`define LLC_SET_BITS 4
`define LLC_TAG_BITS 8

// one line is a single 32-bit word
`define LINE_BITS 32

// requester transaction id
`define REQ_ID_BITS 4

`endif
